// ==== common/rf_cfg.svh ====
`ifndef RF_CFG_SVH
`define RF_CFG_SVH

// width of one general register
`define RF_DATA_W 32

// number of general registers
`define RF_REG_COUNT 32

// destination of jal
`define RF_LINK_REG 31

// result register, exported continuously
`define RF_V0_REG 2

`endif

// ==== common/rf_pkg.sv ====
package rf_pkg;

	// index into the general register file
	typedef logic [4:0] reg_addr_t;

	// primary opcodes of the unaligned loads
	localparam logic [5:0] OP_LWL = 6'b100010;
	localparam logic [5:0] OP_LWR = 6'b100110;

	// register format, used by arithmetic and jalr
	typedef struct packed {
		logic [5:0] opcode;
		reg_addr_t  rs;
		reg_addr_t  rt;
		reg_addr_t  rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_format_t;

	// immediate format, used by loads and branches
	typedef struct packed {
		logic [5:0]  opcode;
		reg_addr_t   rs;
		reg_addr_t   rt;
		logic [15:0] imm;
	} i_format_t;

	// the same 32-bit word seen through either format
	typedef union packed {
		r_format_t r;
		i_format_t i;
	} instr_word_u;

endpackage

// ==== src/instr_decode.sv ====
`timescale 1ns/1ps
`include "rf_cfg.svh"

module instr_decode (
	input  rf_pkg::instr_word_u   instruction,
	input  logic [`RF_DATA_W-1:0] mem_data,
	input  logic [`RF_DATA_W-1:0] link_addr,
	input  logic                  reg_dst,
	input  logic                  link,
	input  logic                  jalr,
	input  logic                  w_en,
	input  logic                  valid_write,
	input  logic                  active,
	input  logic                  valid_read,
	output rf_pkg::reg_addr_t     rd_addr1,
	output rf_pkg::reg_addr_t     rd_addr2,
	output rf_pkg::reg_addr_t     wr_addr,
	output logic [`RF_DATA_W-1:0] wr_data,
	output logic                  merge_en,
	output logic                  wr_fire,
	output logic                  rd_fire
);

	rf_pkg::reg_addr_t field_rs;
	rf_pkg::reg_addr_t field_rt;
	rf_pkg::reg_addr_t field_rd;
	rf_pkg::reg_addr_t dest_sel;
	logic [5:0]        opcode;
	logic              to_link_reg;

	// operand fields, rd only exists in the R view
	assign field_rs = instruction.i.rs;
	assign field_rt = instruction.i.rt;
	assign field_rd = instruction.r.rd;
	assign opcode   = instruction.i.opcode;

	// both source operands come straight from the instruction
	assign rd_addr1 = field_rs;
	assign rd_addr2 = field_rt;

	// jal writes the fixed link register, jalr writes rd like any R-type
	assign to_link_reg = link && !jalr;

	always_comb begin
		if (reg_dst) begin
			dest_sel = field_rd;
		end else begin
			dest_sel = field_rt;
		end
	end

	always_comb begin
		if (to_link_reg) begin
			wr_addr = rf_pkg::reg_addr_t'(`RF_LINK_REG);
		end else begin
			wr_addr = dest_sel;
		end
	end

	// link address for jal and jalr, load data otherwise
	always_comb begin
		if (link) begin
			wr_data = link_addr;
		end else begin
			wr_data = mem_data;
		end
	end

	// lwl and lwr merge into the old register contents
	assign merge_en = (opcode == rf_pkg::OP_LWL) || (opcode == rf_pkg::OP_LWR);

	// a write in the same cycle suppresses the read
	assign wr_fire = w_en && valid_write;
	assign rd_fire = active && valid_read && !wr_fire;

endmodule

// ==== regfile/reg_array.sv ====
`timescale 1ns/1ps
`include "rf_cfg.svh"

module reg_array (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  wr_fire,
	input  logic                  merge_en,
	input  rf_pkg::reg_addr_t     wr_addr,
	input  logic [`RF_DATA_W-1:0] wr_data,
	input  logic [3:0]            byte_en,
	input  rf_pkg::reg_addr_t     rd_addr1,
	input  rf_pkg::reg_addr_t     rd_addr2,
	output logic [`RF_DATA_W-1:0] rd_data1,
	output logic [`RF_DATA_W-1:0] rd_data2,
	output logic [`RF_DATA_W-1:0] v0_data
);

	logic [`RF_DATA_W-1:0] regs [`RF_REG_COUNT];
	logic [`RF_DATA_W-1:0] old_word;
	logic [`RF_DATA_W-1:0] merged_word;
	logic [`RF_DATA_W-1:0] next_word;
	logic                  wr_zero;
	logic                  wr_commit;

	// byte-lane merge for the unaligned loads
	// upper patterns put the low data bytes at the top of the word
	// lower patterns replace the low bytes in place
	function automatic logic [`RF_DATA_W-1:0] merge_bytes(
		input logic [`RF_DATA_W-1:0] old_val,
		input logic [`RF_DATA_W-1:0] data,
		input logic [3:0]            lanes
	);
		logic [`RF_DATA_W-1:0] result;
		begin
			case (lanes)
				4'b1000: begin
					result = {data[7:0], old_val[23:0]};
				end
				4'b1100: begin
					result = {data[15:0], old_val[15:0]};
				end
				4'b1110: begin
					result = {data[23:0], old_val[7:0]};
				end
				4'b0001: begin
					result = {old_val[31:8], data[7:0]};
				end
				4'b0011: begin
					result = {old_val[31:16], data[15:0]};
				end
				4'b0111: begin
					result = {old_val[31:24], data[23:0]};
				end
				4'b1111: begin
					result = data;
				end
				default: begin
					// unlisted pattern keeps the register as it was
					result = old_val;
				end
			endcase
			merge_bytes = result;
		end
	endfunction

	assign old_word    = regs[wr_addr];
	assign merged_word = merge_bytes(old_word, wr_data, byte_en);

	always_comb begin
		if (merge_en) begin
			next_word = merged_word;
		end else begin
			next_word = wr_data;
		end
	end

	// r0 is never written and stays zero from reset
	assign wr_zero   = (wr_addr == '0);
	assign wr_commit = wr_fire && !wr_zero;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int idx = 0; idx < `RF_REG_COUNT; idx++) begin
				regs[idx] <= '0;
			end
		end else if (wr_commit) begin
			regs[wr_addr] <= next_word;
		end
	end

	// combinational read ports see new data the cycle after a write
	assign rd_data1 = regs[rd_addr1];
	assign rd_data2 = regs[rd_addr2];

	assign v0_data = regs[`RF_V0_REG];

endmodule

// ==== src/operand_read.sv ====
`timescale 1ns/1ps
`include "rf_cfg.svh"

module operand_read (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  wr_fire,
	input  logic                  rd_fire,
	input  logic [`RF_DATA_W-1:0] rd_data1,
	input  logic [`RF_DATA_W-1:0] rd_data2,
	output logic [`RF_DATA_W-1:0] read_data1,
	output logic [`RF_DATA_W-1:0] read_data2,
	output logic                  v_read,
	output logic                  end_instr_reg
);

	// operand capture, held between reads
	always_ff @(posedge clk) begin
		if (reset) begin
			read_data1 <= '0;
			read_data2 <= '0;
		end else if (rd_fire) begin
			read_data1 <= rd_data1;
			read_data2 <= rd_data2;
		end
	end

	// one-cycle pulse after each accepted read
	always_ff @(posedge clk) begin
		if (reset) begin
			v_read <= 1'b0;
		end else begin
			v_read <= rd_fire;
		end
	end

	// tells the PC the instruction is done
	// a write finishes it, a read starts the operand phase
	always_ff @(posedge clk) begin
		if (reset) begin
			end_instr_reg <= 1'b1;
		end else if (wr_fire) begin
			end_instr_reg <= 1'b1;
		end else if (rd_fire) begin
			end_instr_reg <= 1'b0;
		end
	end

endmodule

// ==== src/regfile_top.sv ====
`timescale 1ns/1ps
`include "rf_cfg.svh"

module regfile_top (
	input  logic                  clk,
	input  logic                  reset,
	input  rf_pkg::instr_word_u   instruction,
	input  logic [`RF_DATA_W-1:0] mem_data,
	input  logic [`RF_DATA_W-1:0] link_addr,
	input  logic [3:0]            byte_en,
	input  logic                  reg_dst,
	input  logic                  link,
	input  logic                  jalr,
	input  logic                  w_en,
	input  logic                  valid_write,
	input  logic                  active,
	input  logic                  valid_read,
	output logic [`RF_DATA_W-1:0] read_data1,
	output logic [`RF_DATA_W-1:0] read_data2,
	output logic [`RF_DATA_W-1:0] register_v0,
	output logic                  v_read,
	output logic                  end_instr_reg
);

	rf_pkg::reg_addr_t     rd_addr1;
	rf_pkg::reg_addr_t     rd_addr2;
	rf_pkg::reg_addr_t     wr_addr;
	logic [`RF_DATA_W-1:0] wr_data;
	logic [`RF_DATA_W-1:0] rd_data1;
	logic [`RF_DATA_W-1:0] rd_data2;
	logic                  merge_en;
	logic                  wr_fire;
	logic                  rd_fire;

	instr_decode u_instr_decode (
		.instruction (instruction),
		.mem_data    (mem_data),
		.link_addr   (link_addr),
		.reg_dst     (reg_dst),
		.link        (link),
		.jalr        (jalr),
		.w_en        (w_en),
		.valid_write (valid_write),
		.active      (active),
		.valid_read  (valid_read),
		.rd_addr1    (rd_addr1),
		.rd_addr2    (rd_addr2),
		.wr_addr     (wr_addr),
		.wr_data     (wr_data),
		.merge_en    (merge_en),
		.wr_fire     (wr_fire),
		.rd_fire     (rd_fire)
	);

	reg_array u_reg_array (
		.clk      (clk),
		.reset    (reset),
		.wr_fire  (wr_fire),
		.merge_en (merge_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.byte_en  (byte_en),
		.rd_addr1 (rd_addr1),
		.rd_addr2 (rd_addr2),
		.rd_data1 (rd_data1),
		.rd_data2 (rd_data2),
		.v0_data  (register_v0)
	);

	operand_read u_operand_read (
		.clk           (clk),
		.reset         (reset),
		.wr_fire       (wr_fire),
		.rd_fire       (rd_fire),
		.rd_data1      (rd_data1),
		.rd_data2      (rd_data2),
		.read_data1    (read_data1),
		.read_data2    (read_data2),
		.v_read        (v_read),
		.end_instr_reg (end_instr_reg)
	);

endmodule

// ==== verif/regfile_assertions.sv ====
`timescale 1ns/1ps
`include "rf_cfg.svh"

module regfile_assertions (
	input logic                  clk,
	input logic                  reset,
	input logic                  w_en,
	input logic                  valid_write,
	input logic                  active,
	input logic                  valid_read,
	input logic                  v_read,
	input logic                  end_instr_reg,
	input logic [`RF_DATA_W-1:0] register_v0
);

	logic read_strobe;

	// read as accepted by the block, a write in the same cycle wins
	assign read_strobe = active && valid_read && !(w_en && valid_write);

	pulse_needs_strobe: assert property (@(posedge clk) disable iff (reset)
		(v_read && $past(v_read)) |-> $past(read_strobe))
		else $error("v_read stayed high without a new read strobe");

	flags_after_reset: assert property (@(posedge clk)
		$fell(reset) |-> (!v_read && end_instr_reg))
		else $error("v_read or end_instr_reg wrong after reset");

	v0_after_reset: assert property (@(posedge clk)
		$fell(reset) |-> (register_v0 == '0))
		else $error("register_v0 not zero after reset");

endmodule

bind regfile_top regfile_assertions u_regfile_assertions (
	.clk           (clk),
	.reset         (reset),
	.w_en          (w_en),
	.valid_write   (valid_write),
	.active        (active),
	.valid_read    (valid_read),
	.v_read        (v_read),
	.end_instr_reg (end_instr_reg),
	.register_v0   (register_v0)
);

// ==== verif/regfile_tb.sv ====
`timescale 1ns/1ps
`include "rf_cfg.svh"

module regfile_tb;

	localparam int MAX_LINES = 64;

	logic                  clk;
	logic                  reset;
	rf_pkg::instr_word_u   instruction;
	logic [`RF_DATA_W-1:0] mem_data;
	logic [`RF_DATA_W-1:0] link_addr;
	logic [3:0]            byte_en;
	logic                  reg_dst;
	logic                  link;
	logic                  jalr;
	logic                  w_en;
	logic                  valid_write;
	logic                  active;
	logic                  valid_read;
	logic [`RF_DATA_W-1:0] read_data1;
	logic [`RF_DATA_W-1:0] read_data2;
	logic [`RF_DATA_W-1:0] register_v0;
	logic                  v_read;
	logic                  end_instr_reg;

	// one entry per trace line
	logic [7:0]            op_list [MAX_LINES];
	logic [31:0]           instr_list [MAX_LINES];
	logic [`RF_DATA_W-1:0] mem_list [MAX_LINES];
	logic [`RF_DATA_W-1:0] link_list [MAX_LINES];
	logic [3:0]            be_list [MAX_LINES];
	logic [2:0]            flag_list [MAX_LINES];
	logic [`RF_DATA_W-1:0] exp1_list [MAX_LINES];
	logic [`RF_DATA_W-1:0] exp2_list [MAX_LINES];
	logic [`RF_DATA_W-1:0] expv0_list [MAX_LINES];

	int   line_count;
	int   error_count;
	int   check_count;
	int   cycle_count;
	int   cycle_limit;
	logic model_end;

	regfile_top u_regfile_top (
		.clk           (clk),
		.reset         (reset),
		.instruction   (instruction),
		.mem_data      (mem_data),
		.link_addr     (link_addr),
		.byte_en       (byte_en),
		.reg_dst       (reg_dst),
		.link          (link),
		.jalr          (jalr),
		.w_en          (w_en),
		.valid_write   (valid_write),
		.active        (active),
		.valid_read    (valid_read),
		.read_data1    (read_data1),
		.read_data2    (read_data2),
		.register_v0   (register_v0),
		.v_read        (v_read),
		.end_instr_reg (end_instr_reg)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// limit is zero until the trace is loaded
	initial begin
		cycle_count = 0;
		while (cycle_limit == 0 || cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("ERROR: timeout, the run did not finish within %0d cycles", cycle_limit);
		$display("Result: FAILED");
		$finish;
	end

	task automatic compare_word(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		assert (actual === expected)
		else begin
			$display("MISMATCH at %0t: %s expected %h, actual %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic load_trace();
		int                fd;
		int                code;
		logic [8*16-1:0]   tok;
		logic [8*256-1:0]  rest;
		fd = $fopen("verif/regfile_trace.txt", "r");
		if (fd == 0) begin
			$display("ERROR: could not open the trace file verif/regfile_trace.txt");
			error_count++;
		end else begin
			while (!$feof(fd) && line_count < MAX_LINES) begin
				code = $fscanf(fd, "%s", tok);
				if (code == 1) begin
					if (tok[7:0] == "#") begin
						code = $fgets(rest, fd);
					end else begin
						code = $fscanf(fd, "%h %h %h %b %b %h %h %h",
							instr_list[line_count], mem_list[line_count],
							link_list[line_count], be_list[line_count],
							flag_list[line_count], exp1_list[line_count],
							exp2_list[line_count], expv0_list[line_count]);
						if (code != 8) begin
							$display("ERROR: trace line %0d has missing or bad fields", line_count + 1);
							error_count++;
						end
						op_list[line_count] = tok[7:0];
						line_count++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic drive_line(input int idx);
		logic [7:0] op;
		op = op_list[idx];
		if (op != "W" && op != "R" && op != "B" && op != "I") begin
			$display("ERROR: trace entry %0d has an unknown operation letter", idx + 1);
			error_count++;
		end
		instruction <= instr_list[idx];
		mem_data    <= mem_list[idx];
		link_addr   <= link_list[idx];
		byte_en     <= be_list[idx];
		reg_dst     <= flag_list[idx][2];
		link        <= flag_list[idx][1];
		jalr        <= flag_list[idx][0];
		w_en        <= (op == "W") || (op == "B");
		valid_write <= (op == "W") || (op == "B");
		active      <= (op == "R") || (op == "B");
		valid_read  <= (op == "R") || (op == "B");
	endtask

	task automatic drive_idle();
		w_en        <= 1'b0;
		valid_write <= 1'b0;
		active      <= 1'b0;
		valid_read  <= 1'b0;
	endtask

	// a write finishes the instruction, a read reopens it, idle holds
	task automatic check_line(input int idx);
		logic [7:0] op;
		op = op_list[idx];
		if (op == "W" || op == "B") begin
			model_end = 1'b1;
		end else if (op == "R") begin
			model_end = 1'b0;
		end
		compare_word("read_data1", read_data1, exp1_list[idx]);
		compare_word("read_data2", read_data2, exp2_list[idx]);
		compare_word("register_v0", register_v0, expv0_list[idx]);
		compare_word("v_read", {31'b0, v_read}, {31'b0, op == "R"});
		compare_word("end_instr_reg", {31'b0, end_instr_reg}, {31'b0, model_end});
	endtask

	initial begin
		int idx;
		reset       <= 1'b1;
		instruction <= '0;
		mem_data    <= '0;
		link_addr   <= '0;
		byte_en     <= '0;
		reg_dst     <= 1'b0;
		link        <= 1'b0;
		jalr        <= 1'b0;
		w_en        <= 1'b0;
		valid_write <= 1'b0;
		active      <= 1'b0;
		valid_read  <= 1'b0;
		model_end = 1'b1;
		load_trace();
		cycle_limit = 4 * line_count + 20;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		compare_word("read_data1", read_data1, '0);
		compare_word("read_data2", read_data2, '0);
		compare_word("register_v0", register_v0, '0);
		compare_word("v_read", {31'b0, v_read}, 32'd0);
		compare_word("end_instr_reg", {31'b0, end_instr_reg}, 32'd1);
		// each line is checked on the falling edge one cycle after it is driven
		for (idx = 0; idx <= line_count; idx++) begin
			@(posedge clk);
			if (idx < line_count) begin
				drive_line(idx);
			end else begin
				drive_idle();
			end
			@(negedge clk);
			if (idx > 0) begin
				check_line(idx - 1);
			end
		end
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

// ==== verif/regfile_trace.txt ====
# op instruction mem_data link_addr byte_en flags exp_read_data1 exp_read_data2 exp_register_v0
# flags are reg_dst link jalr; op W write, R read, B write and read strobes, I idle
R 00BF0000 00000000 00000000 0000 000 00000000 00000000 00000000
I 00000000 00000000 00000000 0000 000 00000000 00000000 00000000
# destination select, rd then rt, then jal and jalr
W 00001000 11223344 00000000 0000 100 00000000 00000000 11223344
W 8C033800 A5A5F00D 00000000 0000 000 00000000 00000000 11223344
R 00430000 00000000 00000000 0000 000 11223344 A5A5F00D 11223344
W 0C042800 DEADBEEF 00400010 0000 010 11223344 A5A5F00D 11223344
W 01203000 CAFEBABE 00400024 0000 111 11223344 A5A5F00D 11223344
R 03E60000 00000000 00000000 0000 000 00400010 00400024 11223344
W 8C020000 0000BEEF 00000000 0000 000 00400010 00400024 0000BEEF
R 00440000 00000000 00000000 0000 000 0000BEEF 00000000 0000BEEF
# register zero
W 00000000 FFFFFFFF 00000000 0000 100 0000BEEF 00000000 0000BEEF
W 8C000000 12345678 00000000 0000 000 0000BEEF 00000000 0000BEEF
R 00000000 00000000 00000000 0000 000 00000000 00000000 0000BEEF
W 00000000 55555555 00000000 0000 100 00000000 00000000 0000BEEF
# lwl into r8, lwr into r9
W 8C080000 8899AABB 00000000 0000 000 00000000 00000000 0000BEEF
W 8C090000 10203040 00000000 0000 000 00000000 00000000 0000BEEF
W 88080000 777777C1 00000000 1000 000 00000000 00000000 0000BEEF
W 98090000 666666D1 00000000 0001 000 00000000 00000000 0000BEEF
R 01090000 00000000 00000000 0000 000 C199AABB 102030D1 0000BEEF
W 88080000 5555D2E3 00000000 1100 000 C199AABB 102030D1 0000BEEF
W 98090000 4444E2F3 00000000 0011 000 C199AABB 102030D1 0000BEEF
R 01090000 00000000 00000000 0000 000 D2E3AABB 1020E2F3 0000BEEF
W 88080000 33F4A5B6 00000000 1110 000 D2E3AABB 1020E2F3 0000BEEF
W 98090000 22C5D6E7 00000000 0111 000 D2E3AABB 1020E2F3 0000BEEF
R 01090000 00000000 00000000 0000 000 F4A5B6BB 10C5D6E7 0000BEEF
W 88080000 01234567 00000000 1111 000 F4A5B6BB 10C5D6E7 0000BEEF
W 98090000 FFFFFFFF 00000000 0101 000 F4A5B6BB 10C5D6E7 0000BEEF
R 01090000 00000000 00000000 0000 000 01234567 10C5D6E7 0000BEEF
# write wins over a read in the same cycle
B 8D4A0000 0BADF00D 00000000 0000 000 01234567 10C5D6E7 0000BEEF
R 01430000 00000000 00000000 0000 000 0BADF00D A5A5F00D 0000BEEF
I 00000000 00000000 00000000 0000 000 0BADF00D A5A5F00D 0000BEEF
R 03E20000 00000000 00000000 0000 000 00400010 0000BEEF 0000BEEF
R 00C80000 00000000 00000000 0000 000 00400024 01234567 0000BEEF
I 00000000 00000000 00000000 0000 000 00400024 01234567 0000BEEF
W 00001000 600DCAFE 00000000 0000 100 00400024 01234567 600DCAFE
I 00000000 00000000 00000000 0000 000 00400024 01234567 600DCAFE

// ==== tb.f ====
+incdir+common
common/rf_pkg.sv
src/instr_decode.sv
regfile/reg_array.sv
src/operand_read.sv
src/regfile_top.sv
verif/regfile_assertions.sv
verif/regfile_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the register file testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps --top-module regfile_tb \
	-f tb.f -o regfile_sim \
	&& ./obj_dir/regfile_sim > sim.log 2>&1 \
	|| echo "build or simulation did not complete"
cat sim.log 2>/dev/null
grep -q "^Result: PASSED$" sim.log && exit 0 || exit 1
